//--- source/invaders_pkg.sv
`default_nettype none

package invaders_pkg;

	//////////////////////////////
	// Basic types

	// Screen coordinate, wide enough for off-screen scan positions
	typedef logic [10:0] coord_t;

	// Colour byte, blue in the top bits, then green, then red
	typedef logic [7:0] rgb_t;

	// Current scan position
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_pos_t;

	// One sprite part's claim on the current pixel
	typedef struct packed {
		logic hit;
		rgb_t colour;
	} sprite_hit_t;

	// Screen modes, stepped by the display button
	typedef enum logic [1:0] {
		MODE_BLANK = 2'd0,
		MODE_START = 2'd1,
		MODE_GAME  = 2'd2
	} display_mode_t;

	// Sideways direction of the alien formation
	typedef enum logic {
		MARCH_RIGHT = 1'b0,
		MARCH_LEFT  = 1'b1
	} march_dir_t;

	//////////////////////////////
	// Screen and border rows
	localparam coord_t SCREEN_W          = 11'd640;
	localparam coord_t SCREEN_H          = 11'd480;
	localparam coord_t SCOREBOARD_TOP    = 11'd0;
	localparam coord_t SCOREBOARD_BOTTOM = 11'd60;
	localparam coord_t BARRIER_BOTTOM    = 11'd400;
	localparam coord_t EXTRA_LIVES_TOP   = 11'd445;
	localparam coord_t SCREEN_LAST_ROW   = 11'd479;

	//////////////////////////////
	// Colours
	localparam rgb_t COLOR_SPACESHIP = 8'b01111000;
	localparam rgb_t COLOR_ALIEN     = 8'b10101010;
	localparam rgb_t COLOR_BLACK     = 8'b00000000;
	localparam rgb_t COLOR_SPACE     = COLOR_BLACK;
	localparam rgb_t COLOR_GREEN     = 8'b00111000;
	localparam rgb_t COLOR_BLUE      = 8'b11000000;
	localparam rgb_t COLOR_YELLOW    = 8'b00111111;
	// Solid fill for the start screen
	localparam rgb_t COLOR_START     = COLOR_YELLOW;

	//////////////////////////////
	// Ship geometry
	localparam coord_t SHIP_Y_TOP   = 11'd410;
	localparam coord_t SHIP_W       = 11'd40;
	localparam coord_t SHIP_H       = 11'd20;
	localparam coord_t SHIP_X_START = 11'd300;
	// Rightmost ship x, keeps the ship fully on screen
	localparam coord_t SHIP_X_MAX   = 11'd600;

	// Alien cell and formation geometry
	localparam coord_t ALIEN_W       = 11'd30;
	localparam coord_t ALIEN_H       = 11'd20;
	localparam coord_t ALIEN_PITCH_X = 11'd50;
	localparam coord_t ALIEN_PITCH_Y = 11'd30;
	localparam coord_t ALIEN_X_START = 11'd195;
	localparam coord_t ALIEN_Y_START = 11'd150;
	localparam coord_t ALIEN_STEP    = 11'd5;
	localparam coord_t ALIEN_DROP    = 11'd10;

endpackage

`default_nettype wire

//--- source/game_mode_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module game_mode_fsm import invaders_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          button_display,
	output display_mode_t mode,
	output logic          restart
);

	display_mode_t mode_next;

	// Blank, start, game, and round again
	always_comb begin
		case (mode)
			MODE_BLANK: mode_next = MODE_START;
			MODE_START: mode_next = MODE_GAME;
			MODE_GAME:  mode_next = MODE_BLANK;
			default:    mode_next = MODE_BLANK;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode    <= MODE_BLANK;
			restart <= 1'b0;
		end else begin
			// High in the first cycle of game mode only
			restart <= button_display && (mode == MODE_START);
			if (button_display) begin
				mode <= mode_next;
			end
		end
	end

	// Encoding 2'd3 is never reached
	mode_legal: assert property (@(posedge clk) disable iff (rst)
		mode inside {MODE_BLANK, MODE_START, MODE_GAME});

endmodule

`default_nettype wire

//--- source/ship_control.sv
`timescale 1ns/1ns
`default_nettype none

module ship_control import invaders_pkg::*; #(
	parameter int SHIP_STEP = 4
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          restart,
	input  logic          move_tick,
	input  logic          button_left,
	input  logic          button_right,
	input  display_mode_t mode,
	input  pixel_pos_t    pos,
	output sprite_hit_t   ship_hit
);

	localparam coord_t STEP = coord_t'(SHIP_STEP);

	coord_t      ship_x;
	logic [11:0] right_sum;
	logic        move_en;
	logic        go_left;
	logic        go_right;
	logic        in_ship;

	//////////////////////////////
	// Position register

	// Ticks only count in game mode
	assign move_en = move_tick && (mode == MODE_GAME);
	// Both buttons held cancel out
	assign go_left  = button_left && !button_right;
	assign go_right = button_right && !button_left;
	// One extra bit so a large step cannot wrap
	assign right_sum = {1'b0, ship_x} + {1'b0, STEP};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x <= SHIP_X_START;
		end else if (restart) begin
			ship_x <= SHIP_X_START;
		end else if (move_en) begin
			if (go_left) begin
				// Clamp at the left screen edge
				ship_x <= (ship_x < STEP) ? '0 : ship_x - STEP;
			end else if (go_right) begin
				// Clamp at the right limit
				ship_x <= (right_sum > {1'b0, SHIP_X_MAX}) ? SHIP_X_MAX : right_sum[10:0];
			end
		end
	end

	//////////////////////////////
	// Hit test, straight from pos
	assign in_ship = (pos.x >= ship_x) && (pos.x < ship_x + SHIP_W) &&
		(pos.y >= SHIP_Y_TOP) && (pos.y < SHIP_Y_TOP + SHIP_H);

	assign ship_hit = '{hit: in_ship, colour: COLOR_SPACESHIP};

	// Ship stays fully on screen
	ship_in_range: assert property (@(posedge clk) disable iff (rst)
		ship_x <= SHIP_X_MAX);

endmodule

`default_nettype wire

//--- source/alien_formation.sv
`timescale 1ns/1ns
`default_nettype none

module alien_formation import invaders_pkg::*; #(
	parameter int ALIEN_COLS = 6,
	parameter int ALIEN_ROWS = 2
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          restart,
	input  logic          move_tick,
	input  display_mode_t mode,
	input  pixel_pos_t    pos,
	output sprite_hit_t   alien_hit
);

	// Left edge of the first column to right edge of the last
	localparam coord_t FORM_W = coord_t'((ALIEN_COLS - 1) * ALIEN_PITCH_X + ALIEN_W);

	coord_t                origin_x;
	coord_t                origin_y;
	march_dir_t            dir;
	logic [11:0]           right_extent;
	logic                  at_right;
	logic                  at_left;
	logic                  move_en;
	coord_t                off_x;
	coord_t                off_y;
	logic                  in_x;
	logic                  in_y;
	logic [ALIEN_COLS-1:0] col_hit;
	logic [ALIEN_ROWS-1:0] row_hit;

	//////////////////////////////
	// March state

	assign move_en = move_tick && (mode == MODE_GAME);

	// Right edge after one more step
	assign right_extent = {1'b0, origin_x} + {1'b0, FORM_W} + {1'b0, ALIEN_STEP};

	// Edge checks only apply in the current direction
	assign at_right = (dir == MARCH_RIGHT) && (right_extent > {1'b0, SCREEN_W});
	assign at_left  = (dir == MARCH_LEFT) && (origin_x < ALIEN_STEP);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			origin_x <= ALIEN_X_START;
			origin_y <= ALIEN_Y_START;
			dir      <= MARCH_RIGHT;
		end else if (restart) begin
			origin_x <= ALIEN_X_START;
			origin_y <= ALIEN_Y_START;
			dir      <= MARCH_RIGHT;
		end else if (move_en) begin
			if (at_right || at_left) begin
				// Drop and turn, no sideways move on this tick
				origin_y <= origin_y + ALIEN_DROP;
				dir      <= (dir == MARCH_RIGHT) ? MARCH_LEFT : MARCH_RIGHT;
			end else if (dir == MARCH_RIGHT) begin
				origin_x <= origin_x + ALIEN_STEP;
			end else begin
				origin_x <= origin_x - ALIEN_STEP;
			end
		end
	end

	//////////////////////////////
	// Grid hit test

	// Offset from the origin, only meaningful when in_x / in_y
	assign in_x  = pos.x >= origin_x;
	assign in_y  = pos.y >= origin_y;
	assign off_x = pos.x - origin_x;
	assign off_y = pos.y - origin_y;

	// Grid is a plain product, so columns and rows test apart
	for (genvar c = 0; c < ALIEN_COLS; c++) begin : g_col
		localparam coord_t CELL_X = coord_t'(c * ALIEN_PITCH_X);
		assign col_hit[c] = in_x && (off_x >= CELL_X) && (off_x < CELL_X + ALIEN_W);
	end

	for (genvar r = 0; r < ALIEN_ROWS; r++) begin : g_row
		localparam coord_t CELL_Y = coord_t'(r * ALIEN_PITCH_Y);
		assign row_hit[r] = in_y && (off_y >= CELL_Y) && (off_y < CELL_Y + ALIEN_H);
	end

	assign alien_hit = '{hit: (|col_hit) && (|row_hit), colour: COLOR_ALIEN};

	// Formation never crosses the right screen edge
	formation_on_screen: assert property (@(posedge clk) disable iff (rst)
		({1'b0, origin_x} + {1'b0, FORM_W}) <= {1'b0, SCREEN_W});

endmodule

`default_nettype wire

//--- source/pixel_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_mixer import invaders_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  display_mode_t mode,
	input  pixel_pos_t    pos,
	input  sprite_hit_t   ship_hit,
	input  sprite_hit_t   alien_hit,
	output rgb_t          rgb
);

	logic on_screen;
	logic row_green;
	logic row_blue;
	rgb_t rgb_next;

	assign on_screen = (pos.x < SCREEN_W) && (pos.y < SCREEN_H);

	// Fixed border rows of the game screen
	assign row_green = (pos.y == SCOREBOARD_TOP) || (pos.y == SCOREBOARD_BOTTOM) ||
		(pos.y == EXTRA_LIVES_TOP) || (pos.y == SCREEN_LAST_ROW);
	assign row_blue  = pos.y == BARRIER_BOTTOM;

	//////////////////////////////
	// Colour select
	always_comb begin
		rgb_next = COLOR_BLACK;
		if (on_screen) begin
			case (mode)
				MODE_START: rgb_next = COLOR_START;
				MODE_GAME: begin
					// Borders, ship, aliens, space
					if (row_green) begin
						rgb_next = COLOR_GREEN;
					end else if (row_blue) begin
						rgb_next = COLOR_BLUE;
					end else if (ship_hit.hit) begin
						rgb_next = ship_hit.colour;
					end else if (alien_hit.hit) begin
						rgb_next = alien_hit.colour;
					end else begin
						rgb_next = COLOR_SPACE;
					end
				end
				default: rgb_next = COLOR_BLACK;
			endcase
		end
	end

	// One cycle from pos to rgb
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= COLOR_BLACK;
		end else begin
			rgb <= rgb_next;
		end
	end

endmodule

`default_nettype wire

//--- source/invaders_top.sv
`timescale 1ns/1ns
`default_nettype none

module invaders_top import invaders_pkg::*; #(
	parameter int ALIEN_COLS = 6,
	parameter int ALIEN_ROWS = 2,
	parameter int SHIP_STEP  = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       button_display,
	input  logic       button_left,
	input  logic       button_right,
	input  logic       move_tick,
	input  pixel_pos_t pos,
	output rgb_t       rgb
);

	display_mode_t mode;
	logic          restart;
	sprite_hit_t   ship_hit;
	sprite_hit_t   alien_hit;

	//////////////////////////////
	// Screen mode
	game_mode_fsm i_mode (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.mode           (mode),
		.restart        (restart)
	);

	//////////////////////////////
	// Sprite parts, side by side
	ship_control #(
		.SHIP_STEP (SHIP_STEP)
	) i_ship (
		.clk          (clk),
		.rst          (rst),
		.restart      (restart),
		.move_tick    (move_tick),
		.button_left  (button_left),
		.button_right (button_right),
		.mode         (mode),
		.pos          (pos),
		.ship_hit     (ship_hit)
	);

	alien_formation #(
		.ALIEN_COLS (ALIEN_COLS),
		.ALIEN_ROWS (ALIEN_ROWS)
	) i_aliens (
		.clk       (clk),
		.rst       (rst),
		.restart   (restart),
		.move_tick (move_tick),
		.mode      (mode),
		.pos       (pos),
		.alien_hit (alien_hit)
	);

	// Registered colour out
	pixel_mixer i_mixer (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.pos       (pos),
		.ship_hit  (ship_hit),
		.alien_hit (alien_hit),
		.rgb       (rgb)
	);

endmodule

`default_nettype wire

//--- bench/invaders_checker.sv
`timescale 1ns/1ns
`default_nettype none

module invaders_checker import invaders_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       probe,
	input  rgb_t       expected,
	input  pixel_pos_t pos,
	input  rgb_t       rgb,
	output int         pass_count,
	output int         fail_count
);

	logic       pending;
	rgb_t       expected_q;
	pixel_pos_t pos_q;

	//////////////////////////////
	// Probe capture

	// The DUT registers the probe colour on this same edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending    <= 1'b0;
			expected_q <= '0;
			pos_q      <= '0;
		end else begin
			pending    <= probe;
			expected_q <= expected;
			pos_q      <= pos;
		end
	end

	//////////////////////////////
	// Compare and report

	// Half a cycle after the edge, rgb is settled
	always @(negedge clk) begin
		if (rst) begin
			pass_count = 0;
			fail_count = 0;
		end else if (pending) begin
			if (rgb === expected_q) begin
				pass_count = pass_count + 1;
				$display("probe %0d at (%0d,%0d): rgb %b ok",
					pass_count + fail_count, pos_q.x, pos_q.y, rgb);
			end else begin
				fail_count = fail_count + 1;
				$display("CHECK FAILED time %0t: rgb expected %b actual %b at (%0d,%0d)",
					$time, expected_q, rgb, pos_q.x, pos_q.y);
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_invaders.sv
`timescale 1ns/1ns
`default_nettype none

module tb_invaders import invaders_pkg::*; ();

	localparam int ALIEN_COLS  = 6;
	localparam int ALIEN_ROWS  = 2;
	localparam int SHIP_STEP   = 4;
	// Cycles allowed for one probe result
	localparam int PROBE_LIMIT = 10;

	typedef enum logic [2:0] {
		ACT_DISPLAY,
		ACT_TICK_LEFT,
		ACT_TICK_RIGHT,
		ACT_TICK_NONE,
		ACT_PROBE
	} action_t;

	// One table row, expected only used by probes
	typedef struct packed {
		action_t    act;
		pixel_pos_t pos;
		rgb_t       expected;
	} stim_row_t;

	logic       clk;
	logic       rst;
	logic       button_display;
	logic       button_left;
	logic       button_right;
	logic       move_tick;
	pixel_pos_t pos;
	rgb_t       rgb;
	logic       probe;
	rgb_t       probe_expected;
	int         pass_count;
	int         fail_count;

	// Reference model of the game state
	display_mode_t m_mode;
	march_dir_t    m_dir;
	int            m_ship_x;
	int            m_alien_x;
	int            m_alien_y;

	stim_row_t table_q[$];
	int        probes_sent;
	bit        timed_out;
	bit        row_ok;

	always #4 clk = ~clk;

	invaders_top #(
		.ALIEN_COLS (ALIEN_COLS),
		.ALIEN_ROWS (ALIEN_ROWS),
		.SHIP_STEP  (SHIP_STEP)
	) i_dut (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.button_left    (button_left),
		.button_right   (button_right),
		.move_tick      (move_tick),
		.pos            (pos),
		.rgb            (rgb)
	);

	invaders_checker i_checker (
		.clk        (clk),
		.rst        (rst),
		.probe      (probe),
		.expected   (probe_expected),
		.pos        (pos),
		.rgb        (rgb),
		.pass_count (pass_count),
		.fail_count (fail_count)
	);

	//////////////////////////////
	// Expected colour from the model

	function automatic rgb_t expected_colour(input int x, input int y);
		int cx;
		int cy;
		if (x >= SCREEN_W || y >= SCREEN_H || m_mode == MODE_BLANK)
			return COLOR_BLACK;
		if (m_mode == MODE_START)
			return COLOR_START;
		// Game screen, borders first
		if (y == SCOREBOARD_TOP || y == SCOREBOARD_BOTTOM ||
			y == EXTRA_LIVES_TOP || y == SCREEN_LAST_ROW)
			return COLOR_GREEN;
		if (y == BARRIER_BOTTOM)
			return COLOR_BLUE;
		if (x >= m_ship_x && x < m_ship_x + SHIP_W && y >= SHIP_Y_TOP && y < SHIP_Y_TOP + SHIP_H)
			return COLOR_SPACESHIP;
		for (int c = 0; c < ALIEN_COLS; c++) begin
			for (int r = 0; r < ALIEN_ROWS; r++) begin
				cx = m_alien_x + c * ALIEN_PITCH_X;
				cy = m_alien_y + r * ALIEN_PITCH_Y;
				if (x >= cx && x < cx + ALIEN_W && y >= cy && y < cy + ALIEN_H)
					return COLOR_ALIEN;
			end
		end
		return COLOR_SPACE;
	endfunction

	//////////////////////////////
	// Table building

	task automatic push_row(input action_t act, input int x, input int y);
		stim_row_t row;
		row.act      = act;
		row.pos.x    = coord_t'(x);
		row.pos.y    = coord_t'(y);
		row.expected = expected_colour(x, y);
		table_q.push_back(row);
	endtask

	task automatic add_press();
		// Entry to game mode restarts both sprite parts
		case (m_mode)
			MODE_BLANK: m_mode = MODE_START;
			MODE_START: begin
				m_mode    = MODE_GAME;
				m_ship_x  = SHIP_X_START;
				m_alien_x = ALIEN_X_START;
				m_alien_y = ALIEN_Y_START;
				m_dir     = MARCH_RIGHT;
			end
			default: m_mode = MODE_BLANK;
		endcase
		push_row(ACT_DISPLAY, 0, 0);
	endtask

	task automatic add_tick(input action_t act);
		int form_w;
		form_w = (ALIEN_COLS - 1) * int'(ALIEN_PITCH_X) + int'(ALIEN_W);
		if (m_mode == MODE_GAME) begin
			if (act == ACT_TICK_LEFT)
				m_ship_x = (m_ship_x < SHIP_STEP) ? 0 : m_ship_x - SHIP_STEP;
			else if (act == ACT_TICK_RIGHT)
				m_ship_x = (m_ship_x + SHIP_STEP > SHIP_X_MAX) ? SHIP_X_MAX : m_ship_x + SHIP_STEP;
			// Edge reached, drop and turn around
			if ((m_dir == MARCH_RIGHT && m_alien_x + form_w + int'(ALIEN_STEP) > SCREEN_W) ||
				(m_dir == MARCH_LEFT && m_alien_x < int'(ALIEN_STEP))) begin
				m_alien_y = m_alien_y + ALIEN_DROP;
				m_dir     = (m_dir == MARCH_RIGHT) ? MARCH_LEFT : MARCH_RIGHT;
			end else if (m_dir == MARCH_RIGHT) begin
				m_alien_x = m_alien_x + int'(ALIEN_STEP);
			end else begin
				m_alien_x = m_alien_x - int'(ALIEN_STEP);
			end
		end
		push_row(act, 0, 0);
	endtask

	task automatic add_probe(input int x, input int y);
		push_row(ACT_PROBE, x, y);
	endtask

	// Just inside and just outside both ship edges
	task automatic add_ship_edge_probes();
		int y;
		y = SHIP_Y_TOP + 5;
		if (m_ship_x > 0)
			add_probe(m_ship_x - 1, y);
		add_probe(m_ship_x, y);
		add_probe(m_ship_x + SHIP_W - 1, y);
		add_probe(m_ship_x + SHIP_W, y);
	endtask

	// Top-left alien corner and the pixel left of it
	task automatic add_corner_probes();
		add_probe(m_alien_x, m_alien_y);
		if (m_alien_x > 0)
			add_probe(m_alien_x - 1, m_alien_y);
	endtask

	task automatic build_table();
		int gx;
		int gy;
		m_mode    = MODE_BLANK;
		m_ship_x  = SHIP_X_START;
		m_alien_x = ALIEN_X_START;
		m_alien_y = ALIEN_Y_START;
		m_dir     = MARCH_RIGHT;
		// Blank after reset, then start screen
		add_probe(100, 100);
		add_probe(320, 470);
		add_press();
		add_probe(100, 100);
		add_probe(639, 479);
		add_probe(640, 100);
		add_probe(100, 480);
		add_probe(2000, 5);
		// Game screen, borders and sprites
		add_press();
		add_probe(10, SCOREBOARD_TOP);
		add_probe(10, SCOREBOARD_BOTTOM);
		add_probe(10, EXTRA_LIVES_TOP);
		add_probe(10, SCREEN_LAST_ROW);
		add_probe(10, BARRIER_BOTTOM);
		add_probe(SHIP_X_START, SHIP_Y_TOP);
		add_probe(ALIEN_X_START, ALIEN_Y_START);
		// Random pixels in the gaps between columns
		repeat (6) begin
			gx = ALIEN_X_START + ALIEN_W + ($urandom % (ALIEN_PITCH_X - ALIEN_W)) +
				($urandom % (ALIEN_COLS - 1)) * ALIEN_PITCH_X;
			gy = ALIEN_Y_START + ($urandom % (ALIEN_PITCH_Y + ALIEN_H));
			add_probe(gx, gy);
		end
		// Ship moves, then runs into the right clamp
		add_ship_edge_probes();
		repeat (3) begin
			add_tick(ACT_TICK_RIGHT);
			add_ship_edge_probes();
		end
		repeat (2) begin
			add_tick(ACT_TICK_LEFT);
			add_ship_edge_probes();
		end
		add_tick(ACT_TICK_NONE);
		add_ship_edge_probes();
		repeat (80)
			add_tick(ACT_TICK_RIGHT);
		add_ship_edge_probes();
		add_tick(ACT_TICK_RIGHT);
		add_ship_edge_probes();
		// Formation march across both screen edges
		repeat (100) begin
			add_tick(ACT_TICK_NONE);
			add_corner_probes();
		end
		// Blank again, ticks ignored, then back into the game
		add_press();
		add_probe(300, 415);
		repeat (5)
			add_tick(ACT_TICK_RIGHT);
		add_probe(m_alien_x, m_alien_y);
		add_press();
		add_probe(100, 100);
		add_press();
		add_probe(SHIP_X_START, SHIP_Y_TOP);
		add_ship_edge_probes();
		add_corner_probes();
	endtask

	//////////////////////////////
	// Row driver

	task automatic apply_row(input stim_row_t row, output bit ok);
		int cycles;
		ok  = 1'b1;
		pos = row.pos;
		case (row.act)
			ACT_DISPLAY: button_display = 1'b1;
			ACT_TICK_LEFT: begin
				move_tick   = 1'b1;
				button_left = 1'b1;
			end
			ACT_TICK_RIGHT: begin
				move_tick    = 1'b1;
				button_right = 1'b1;
			end
			ACT_TICK_NONE: move_tick = 1'b1;
			default: begin
				probe          = 1'b1;
				probe_expected = row.expected;
				probes_sent    = probes_sent + 1;
			end
		endcase
		@(posedge clk);
		#1;
		button_display = 1'b0;
		move_tick      = 1'b0;
		button_left    = 1'b0;
		button_right   = 1'b0;
		probe          = 1'b0;
		if (row.act == ACT_PROBE) begin
			cycles = 0;
			while (pass_count + fail_count < probes_sent && cycles < PROBE_LIMIT) begin
				@(posedge clk);
				#1;
				cycles = cycles + 1;
			end
			if (pass_count + fail_count < probes_sent) begin
				$display("Timeout: probe %0d got no result within %0d cycles",
					probes_sent, PROBE_LIMIT);
				ok = 1'b0;
			end
		end else begin
			// Idle cycle, lets restart or a move land first
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////
	// Run
	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		button_display = 1'b0;
		button_left    = 1'b0;
		button_right   = 1'b0;
		move_tick      = 1'b0;
		pos            = '0;
		probe          = 1'b0;
		probe_expected = '0;
		probes_sent    = 0;
		timed_out      = 1'b0;
		void'($urandom(24966));
		build_table();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < table_q.size() && !timed_out; i++) begin
			apply_row(table_q[i], row_ok);
			timed_out = !row_ok;
		end
		$display("Probes passed: %0d, failed: %0d", pass_count, fail_count);
		if (timed_out || fail_count != 0) begin
			$display("TESTS FAILED");
		end else begin
			$display("TESTS PASSED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/invaders_pkg.sv
source/game_mode_fsm.sv
source/ship_control.sv
source/alien_formation.sv
source/pixel_mixer.sv
source/invaders_top.sv
bench/invaders_checker.sv
bench/tb_invaders.sv
